/* Makefile */
# Verilator build and run of the decode unit testbench
SOURCES := $(shell cat sim.f)

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VtbDecodeUnit: sim.f $(SOURCES)
	verilator --binary --timing --assert --top-module tbDecodeUnit -f sim.f

run: obj_dir/VtbDecodeUnit
	./obj_dir/VtbDecodeUnit > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* qpBusPkg.sv */
// Wishbone classic register map of the decode unit.
// Word addressed; addresses 5 to 7 read as zero.
package qpBusPkg;

	typedef logic [2:0]  wbAddr_t;
	typedef logic [31:0] wbData_t;

	typedef enum logic [2:0] {
		REG_SLOT0 = 3'd0,
		REG_SLOT1 = 3'd1,
		// Operating mode and extension bits
		REG_CTRL  = 3'd2,
		// Ra and Rb after mapping
		REG_SRC   = 3'd3,
		// Rc, Rcc, read mask and port count
		REG_THIRD = 3'd4
	} regMap_e;

	// Field positions inside the control and readback words
	localparam int ctrlRegxLsb  = 2;
	localparam int srcRbLsb     = 16;
	localparam int thirdRccLsb  = 16;
	localparam int thirdMaskLsb = 20;
	localparam int thirdPortLsb = 24;

endpackage

/* qpDecodeBusPort.sv */
// Wishbone classic slave, single cycle ack, no bursts, no err or rty.
// Writes to read-only or unmapped words are acked and dropped.
`timescale 1ns/1ps

module qpDecodeBusPort import qpIsaPkg::*, qpBusPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	// Wishbone slave side
	input  logic       cyc,
	input  logic       stb,
	input  logic       we,
	input  wbAddr_t    adr,
	input  wbData_t    datIn,
	output wbData_t    datOut,
	output logic       ack,
	// Window and control towards the decoders
	output instrWord_t slot0,
	output instrWord_t slot1,
	output opMode_t    om,
	output regExt_t    regx,
	// Mapped result from the operand mapper
	input  aregno_t    ra,
	input  aregno_t    rb,
	input  aregno_t    rc,
	input  condCode_t  rcc,
	input  readMask_t  mask,
	input  logic [1:0] portCount
);

	logic    access;
	wbData_t readData;

	// A new access is taken only while ack is low, which spaces acks
	// out to one cycle each even when the master holds stb
	assign access = cyc && stb && !ack;

	// ======================================================================
	// Handshake and window registers
	// ======================================================================

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ack    <= 1'b0;
			datOut <= '0;
			slot0  <= '0;
			slot1  <= '0;
			om     <= '0;
			regx   <= '0;
		end else begin
			ack <= access;
			if (access && !we)
				datOut <= readData;
			// Writes land on the same edge that raises ack
			if (access && we) begin
				case (adr)
					REG_SLOT0: slot0 <= datIn;
					REG_SLOT1: slot1 <= datIn;
					REG_CTRL: begin
						om   <= datIn[1:0];
						regx <= datIn[ctrlRegxLsb +: 4];
					end
					default: begin
						// Result and unmapped words ignore the write
					end
				endcase
			end
		end
	end

	// ======================================================================
	// Readback multiplexer
	// ======================================================================

	always_comb begin
		readData = '0;
		case (adr)
			REG_SLOT0: readData = slot0;
			REG_SLOT1: readData = slot1;
			REG_CTRL: begin
				readData[1:0]              = om;
				readData[ctrlRegxLsb +: 4] = regx;
			end
			REG_SRC: begin
				readData[8:0]           = ra;
				readData[srcRbLsb +: 9] = rb;
			end
			REG_THIRD: begin
				readData[8:0]               = rc;
				readData[thirdRccLsb +: 3]  = rcc;
				readData[thirdMaskLsb +: 3] = mask;
				readData[thirdPortLsb +: 2] = portCount;
			end
			default: readData = '0;
		endcase
	end

	// Each transfer gets a single ack pulse, even with stb held high
	assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else $error("qpDecodeBusPort: ack high two cycles in a row");

endmodule

/* qpDecodeRc.sv */
// Combinational Rc and Rcc decode from slot 0 and a REGC postfix in slot 1.
// A REGC postfix in slot 1 wins over whatever slot 0 holds.
`timescale 1ns/1ps

module qpDecodeRc import qpIsaPkg::*; (
	input  instrWord_t slot0,
	input  instrWord_t slot1,
	input  regExt_t    regx,
	output aregno_t    rcReg,
	output condCode_t  rcc,
	output logic       rcValid
);

	logic isRegc;

	assign isRegc = (opcodeOf(slot1) == OP_REGC);

	// ======================================================================
	// Third source selection
	// ======================================================================

	always_comb begin
		rcReg   = '0;
		rcc     = '0;
		rcValid = 1'b0;
		// An immediate third operand means no register is read
		if (!immcOf(slot0)) begin
			case (opcodeOf(slot0))
				// Stores read the data register from the rt field
				OP_STB, OP_STW, OP_STO: begin
					rcReg   = extendReg(rtOf(slot0), regx[0]);
					rcValid = 1'b1;
				end
				OP_SHIFT, OP_R2: begin
					rcReg   = extendReg(rcOf(slot0), regx[3]);
					rcValid = 1'b1;
				end
				default: begin
					rcReg   = '0;
					rcValid = 1'b0;
				end
			endcase
		end
		// The postfix names its register directly, so no extension applies
		if (isRegc) begin
			rcReg   = extendReg(rtOf(slot1), 1'b0);
			rcc     = rccOf(slot1);
			rcValid = 1'b1;
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// A condition code only ever comes from a postfix word
	always_comb begin
		assert (isRegc || rcc == '0)
			else $error("qpDecodeRc: Rcc set without a REGC postfix");
	end

endmodule

/* qpDecodeSrc.sv */
// Combinational Ra and Rb decode for slot 0 only.
// Unread sources come out as register zero.
`timescale 1ns/1ps

module qpDecodeSrc import qpIsaPkg::*; (
	input  instrWord_t slot0,
	input  regExt_t    regx,
	output aregno_t    raReg,
	output aregno_t    rbReg,
	output logic [1:0] srcMask
);

	logic raRead;
	logic rbRead;

	// ======================================================================
	// Which sources the opcode reads
	// ======================================================================

	always_comb begin
		raRead = 1'b0;
		rbRead = 1'b0;
		case (opcodeOf(slot0))
			// Register-register forms and stores read both sources
			OP_R2, OP_SHIFT, OP_STB, OP_STW, OP_STO: begin
				raRead = 1'b1;
				rbRead = 1'b1;
			end
			// Immediate add and load use only the base register
			OP_ADDI, OP_LDO: begin
				raRead = 1'b1;
			end
			default: begin
				raRead = 1'b0;
				rbRead = 1'b0;
			end
		endcase
	end

	// ======================================================================
	// Register numbers
	// ======================================================================

	// Regx bit 1 widens Ra and bit 2 widens Rb into the upper bank
	assign raReg = raRead ? extendReg(raOf(slot0), regx[1]) : '0;
	assign rbReg = rbRead ? extendReg(rbOf(slot0), regx[2]) : '0;

	assign srcMask = {rbRead, raRead};

	// The mapper relies on Rb never being read alone,
	// a single-source form always puts its source in Ra
	always_comb begin
		assert (!srcMask[1] || srcMask[0])
			else $error("qpDecodeSrc: Rb valid without Ra");
	end

endmodule

/* qpDecodeUnit.sv */
// Register specifier stage as a Wishbone classic slave.
// spBase sets the stack pointer of mode 0; mode m uses spBase plus m.
`timescale 1ns/1ps

module qpDecodeUnit import qpIsaPkg::*, qpBusPkg::*; #(
	parameter aregno_t spBase = 9'd65
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    cyc,
	input  logic    stb,
	input  logic    we,
	input  wbAddr_t adr,
	input  wbData_t datIn,
	output wbData_t datOut,
	output logic    ack
);

	// Window and control, held in the bus port
	instrWord_t slot0;
	instrWord_t slot1;
	opMode_t    om;
	regExt_t    regx;
	// Decoder results
	aregno_t    raField;
	aregno_t    rbField;
	logic [1:0] srcMask;
	aregno_t    rcField;
	condCode_t  rcc;
	logic       rcValid;
	// Registered result read back by the host
	aregno_t    ra;
	aregno_t    rb;
	aregno_t    rc;
	condCode_t  rccOut;
	readMask_t  mask;
	logic [1:0] portCount;

	qpDecodeBusPort uBusPort (
		.clk(clk), .rstN(rstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
		.datOut(datOut), .ack(ack),
		.slot0(slot0), .slot1(slot1), .om(om), .regx(regx),
		.ra(ra), .rb(rb), .rc(rc), .rcc(rccOut), .mask(mask), .portCount(portCount)
	);

	// Both decoders look at the same window in parallel
	qpDecodeSrc uDecodeSrc (
		.slot0(slot0), .regx(regx),
		.raReg(raField), .rbReg(rbField), .srcMask(srcMask)
	);

	qpDecodeRc uDecodeRc (
		.slot0(slot0), .slot1(slot1), .regx(regx),
		.rcReg(rcField), .rcc(rcc), .rcValid(rcValid)
	);

	qpOperandMap #(.spBase(spBase)) uOperandMap (
		.clk(clk), .rstN(rstN),
		.raReg(raField), .rbReg(rbField), .srcMask(srcMask),
		.rcReg(rcField), .rcc(rcc), .rcValid(rcValid), .om(om),
		.ra(ra), .rb(rb), .rc(rc), .rccOut(rccOut), .mask(mask), .portCount(portCount)
	);

endmodule

/* qpIsaPkg.sv */
// Instruction word layout and register types for the specifier stage.
// Only the opcodes the decoders act on are listed here.
package qpIsaPkg;

	// Plain vectors for the widths that carry a meaning
	typedef logic [31:0] instrWord_t;
	typedef logic [8:0]  aregno_t;
	typedef logic [5:0]  fieldReg_t;
	typedef logic [1:0]  opMode_t;
	typedef logic [3:0]  regExt_t;
	typedef logic [2:0]  condCode_t;
	// Bit 0 is Ra, bit 1 is Rb, bit 2 is Rc
	typedef logic [2:0]  readMask_t;

	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_R2    = 7'd2,
		OP_SHIFT = 7'd3,
		OP_ADDI  = 7'd4,
		OP_LDO   = 7'd8,
		OP_STB   = 7'd16,
		OP_STW   = 7'd17,
		OP_STO   = 7'd18,
		// Postfix word that supplies Rc and a condition code
		OP_REGC  = 7'd127
	} opcode_e;

	// Field value that names the stack pointer in every mode
	localparam fieldReg_t spField = 6'd63;

	// Field extraction, one helper per field of the word
	function automatic opcode_e opcodeOf(instrWord_t w);
		return opcode_e'(w[6:0]);
	endfunction
	function automatic fieldReg_t rtOf(instrWord_t w);
		return w[12:7];
	endfunction
	function automatic fieldReg_t raOf(instrWord_t w);
		return w[18:13];
	endfunction
	function automatic fieldReg_t rbOf(instrWord_t w);
		return w[24:19];
	endfunction
	function automatic fieldReg_t rcOf(instrWord_t w);
		return w[30:25];
	endfunction
	function automatic logic immcOf(instrWord_t w);
		return w[31];
	endfunction
	// Rcc sits in the low three bits of the ra field of a REGC postfix
	function automatic condCode_t rccOf(instrWord_t w);
		return w[15:13];
	endfunction
	// An extension bit adds 64, which is bit 6 of the register number
	function automatic aregno_t extendReg(fieldReg_t f, logic ext);
		return {2'b00, ext, f};
	endfunction

endpackage

/* qpOperandMap.sv */
// Stack pointer substitution, read mask and port count, registered once.
// Results lag the decoder inputs by exactly one clock.
`timescale 1ns/1ps

module qpOperandMap import qpIsaPkg::*; #(
	parameter aregno_t spBase = 9'd65
) (
	input  logic       clk,
	input  logic       rstN,
	input  aregno_t    raReg,
	input  aregno_t    rbReg,
	input  logic [1:0] srcMask,
	input  aregno_t    rcReg,
	input  condCode_t  rcc,
	input  logic       rcValid,
	input  opMode_t    om,
	output aregno_t    ra,
	output aregno_t    rb,
	output aregno_t    rc,
	output condCode_t  rccOut,
	output readMask_t  mask,
	output logic [1:0] portCount
);

	readMask_t  maskNext;
	aregno_t    raMap;
	aregno_t    rbMap;
	aregno_t    rcMap;
	logic [1:0] countNext;

	// Field 63 names the stack pointer whether or not it was extended,
	// so 63 and 127 both map to the per-mode copy
	function automatic aregno_t mapSp(aregno_t r, logic valid, opMode_t m);
		if (valid && r[8:7] == 2'b00 && r[5:0] == spField)
			return spBase + aregno_t'(m);
		return r;
	endfunction

	assign maskNext = {rcValid, srcMask};

	assign raMap = mapSp(raReg, maskNext[0], om);
	assign rbMap = mapSp(rbReg, maskNext[1], om);
	assign rcMap = mapSp(rcReg, maskNext[2], om);

	// ======================================================================
	// Distinct read ports
	// ======================================================================

	// Count after substitution, as two fields naming 63 and 127 share
	// one stack pointer and therefore one port
	always_comb begin
		countNext = 2'd0;
		if (maskNext[0])
			countNext = countNext + 2'd1;
		if (maskNext[1] && !(maskNext[0] && rbMap == raMap))
			countNext = countNext + 2'd1;
		if (maskNext[2] && !(maskNext[0] && rcMap == raMap)
				&& !(maskNext[1] && rcMap == rbMap))
			countNext = countNext + 2'd1;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ra        <= '0;
			rb        <= '0;
			rc        <= '0;
			rccOut    <= '0;
			mask      <= '0;
			portCount <= 2'd0;
		end else begin
			ra        <= raMap;
			rb        <= rbMap;
			rc        <= rcMap;
			rccOut    <= rcc;
			mask      <= maskNext;
			portCount <= countNext;
		end
	end

	// The register file is never asked for more ports than operands
	assert property (@(posedge clk) disable iff (!rstN)
		portCount <= 2'($countones(mask)))
		else $error("qpOperandMap: port count %0d above mask %b", portCount, mask);

endmodule

/* sim.f */
qpIsaPkg.sv
qpBusPkg.sv
qpDecodeSrc.sv
qpDecodeRc.sv
qpOperandMap.sv
qpDecodeBusPort.sv
qpDecodeUnit.sv
tbDecodeModel.sv
tbDecodeUnit.sv

/* tbDecodeModel.sv */
// Reference decode of the instruction window and checks on the bus readback.
// Assumes the DUT is built with a stack pointer base of 65.
`timescale 1ns/1ps

module tbDecodeModel import qpIsaPkg::*; (
	input  logic            clk,
	input  logic            rstN,
	input  logic            cyc,
	input  logic            stb,
	input  logic            ack,
	input  instrWord_t      slot0,
	input  instrWord_t      slot1,
	input  opMode_t         om,
	input  regExt_t         regx,
	input  logic [8*16-1:0] testName,
	input  logic            checkResult,
	input  logic [31:0]     srcAct,
	input  logic [31:0]     thirdAct,
	input  logic            checkWord,
	input  logic [31:0]     wordExp,
	input  logic [31:0]     wordAct,
	output int              errorCount,
	output int              ackCount
);

	localparam int spExpected = 65;

	logic [31:0] srcExp;
	logic [31:0] thirdExp;
	// One counter per check, summed for the testbench
	int srcErrors = 0;
	int thirdErrors = 0;
	int wordErrors = 0;
	int pulseErrors = 0;
	int strobeErrors = 0;

	// Field 63 names the stack pointer with or without the extension bit
	function automatic int stackMap(input int num, input bit valid, input int mode);
		if (valid && (num == 63 || num == 127))
			return spExpected + mode;
		return num;
	endfunction

	// ======================================================================
	// Expected readback words
	// ======================================================================

	always_comb begin
		bit isStore;
		bit isReg3;
		int nums [3];
		bit vld [3];
		bit seen;
		int ports;
		isStore = slot0[6:0] inside {OP_STB, OP_STW, OP_STO};
		isReg3 = slot0[6:0] inside {OP_R2, OP_SHIFT};
		vld[0] = isStore || isReg3 || slot0[6:0] inside {OP_ADDI, OP_LDO};
		vld[1] = isStore || isReg3;
		vld[2] = 1'b0;
		nums[0] = vld[0] ? int'(slot0[18:13]) + (regx[1] ? 64 : 0) : 0;
		nums[1] = vld[1] ? int'(slot0[24:19]) + (regx[2] ? 64 : 0) : 0;
		nums[2] = 0;
		// Immediate third operand reads no register
		if (!slot0[31] && isStore) begin
			vld[2] = 1'b1;
			nums[2] = int'(slot0[12:7]) + (regx[0] ? 64 : 0);
		end else if (!slot0[31] && isReg3) begin
			vld[2] = 1'b1;
			nums[2] = int'(slot0[30:25]) + (regx[3] ? 64 : 0);
		end
		thirdExp = 32'd0;
		// REGC postfix replaces Rc whatever slot 0 holds
		if (slot1[6:0] == OP_REGC) begin
			vld[2] = 1'b1;
			nums[2] = int'(slot1[12:7]);
			thirdExp[18:16] = slot1[15:13];
		end
		for (int i = 0; i < 3; i++)
			nums[i] = stackMap(nums[i], vld[i], int'(om));
		// Count each valid number once, comparing with earlier valid ones
		ports = 0;
		for (int i = 0; i < 3; i++) begin
			seen = 1'b0;
			for (int j = 0; j < i; j++)
				if (vld[j] && nums[j] == nums[i])
					seen = 1'b1;
			if (vld[i] && !seen)
				ports++;
		end
		srcExp = 32'(nums[0]) | (32'(nums[1]) << 16);
		thirdExp[8:0] = 9'(nums[2]);
		thirdExp[22:20] = {vld[2], vld[1], vld[0]};
		thirdExp[25:24] = 2'(ports);
	end

	// ======================================================================
	// Checks
	// ======================================================================

	assert property (@(posedge clk) disable iff (!rstN) checkResult |-> srcAct == srcExp)
		else begin
			srcErrors = srcErrors + 1;
			$display("[ERROR] %0s: source word expected %h actual %h",
				$sampled(testName), $sampled(srcExp), $sampled(srcAct));
		end

	assert property (@(posedge clk) disable iff (!rstN) checkResult |-> thirdAct == thirdExp)
		else begin
			thirdErrors = thirdErrors + 1;
			$display("[ERROR] %0s: third word expected %h actual %h",
				$sampled(testName), $sampled(thirdExp), $sampled(thirdAct));
		end

	assert property (@(posedge clk) disable iff (!rstN) checkWord |-> wordAct == wordExp)
		else begin
			wordErrors = wordErrors + 1;
			$display("[ERROR] %0s: register word expected %h actual %h",
				$sampled(testName), $sampled(wordExp), $sampled(wordAct));
		end

	// One ack pulse per transfer, and only in answer to a strobe
	assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else begin
			pulseErrors = pulseErrors + 1;
			$display("ack stayed high for a second cycle during %0s", $sampled(testName));
		end

	assert property (@(posedge clk) disable iff (!rstN) ack |-> $past(cyc && stb))
		else begin
			strobeErrors = strobeErrors + 1;
			$display("ack came without a strobe during %0s", $sampled(testName));
		end

	assign errorCount = srcErrors + thirdErrors + wordErrors + pulseErrors + strobeErrors;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ackCount <= 0;
		else if (ack)
			ackCount <= ackCount + 1;
	end

endmodule

/* tbDecodeUnit.sv */
// Drives the decode unit over its Wishbone port with spBase left at 65.
// Stimulus is random from a fixed seed, so a run repeats exactly.
`timescale 1ns/1ps

module tbDecodeUnit import qpIsaPkg::*, qpBusPkg::*;;

	localparam int nBasic = 40;
	localparam int nRegc = 24;
	localparam int nSp = 32;
	localparam int nPort = 32;
	localparam int nUnmapped = 4;
	// Each vector is three writes and two reads and every unmapped pass adds eleven more
	localparam int totalTransfers = 2 + 5 * (nBasic + nRegc + nSp + nPort) + 16 * nUnmapped;

	logic clk;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	wbAddr_t adr;
	wbData_t datIn;
	wbData_t datOut;
	logic ack;
	// Window as the testbench wrote it, seen by the reference model
	instrWord_t winSlot0;
	instrWord_t winSlot1;
	opMode_t winOm;
	regExt_t winRegx;
	logic [8*16-1:0] testName;
	logic checkResult;
	logic checkWord;
	wbData_t srcAct;
	wbData_t thirdAct;
	wbData_t wordExp;
	wbData_t wordAct;
	int modelErrors;
	int ackSeen;
	int tbErrors = 0;
	int transferCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsAtStart = 0;

	qpDecodeUnit #(.spBase(9'd65)) i_dut (
		.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we),
		.adr(adr), .datIn(datIn), .datOut(datOut), .ack(ack)
	);

	tbDecodeModel i_model (
		.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .ack(ack),
		.slot0(winSlot0), .slot1(winSlot1), .om(winOm), .regx(winRegx),
		.testName(testName), .checkResult(checkResult), .srcAct(srcAct),
		.thirdAct(thirdAct), .checkWord(checkWord), .wordExp(wordExp),
		.wordAct(wordAct), .errorCount(modelErrors), .ackCount(ackSeen)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// The watchdog budget scales with the planned number of transfers
	initial begin
		repeat (200 * totalTransfers) @(posedge clk);
		$display("Watchdog expired after %0d cycles without the run finishing",
			200 * totalTransfers);
		$display("TEST FAILED");
		$finish;
	end

	// ======================================================================
	// Bus tasks
	// ======================================================================

	// Stb stays up until ack is seen and then drops for at least a cycle
	task automatic busWrite(input wbAddr_t a, input wbData_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= a;
		datIn <= d;
		@(posedge clk);
		while (!ack) @(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		transferCount++;
	endtask

	task automatic busRead(input wbAddr_t a, output wbData_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= a;
		@(posedge clk);
		while (!ack) @(posedge clk);
		d = datOut;
		cyc <= 1'b0;
		stb <= 1'b0;
		transferCount++;
	endtask

	task automatic applyWindow(input instrWord_t s0, input instrWord_t s1,
			input opMode_t m, input regExt_t x);
		winSlot0 <= s0;
		winSlot1 <= s1;
		winOm <= m;
		winRegx <= x;
		busWrite(REG_SLOT0, s0);
		busWrite(REG_SLOT1, s1);
		busWrite(REG_CTRL, {26'd0, x, m});
	endtask

	// Reads both result words and hands them to the model for one cycle
	task automatic checkReadback();
		wbData_t srcWord;
		wbData_t thirdWord;
		busRead(REG_SRC, srcWord);
		busRead(REG_THIRD, thirdWord);
		@(posedge clk);
		srcAct <= srcWord;
		thirdAct <= thirdWord;
		checkResult <= 1'b1;
		@(posedge clk);
		checkResult <= 1'b0;
	endtask

	task automatic checkWordValue(input wbData_t expected, input wbData_t actual);
		@(posedge clk);
		wordExp <= expected;
		wordAct <= actual;
		checkWord <= 1'b1;
		@(posedge clk);
		checkWord <= 1'b0;
	endtask

	task automatic beginTest(input logic [8*16-1:0] name);
		testName <= name;
		errorsAtStart = modelErrors + tbErrors;
	endtask

	task automatic finishTest();
		int errs;
		// Let the last assertion results settle
		repeat (2) @(posedge clk);
		errs = modelErrors + tbErrors - errorsAtStart;
		testsRun++;
		if (errs != 0)
			testsFailed++;
		$display("%0s: %0s, %0d errors", testName, (errs == 0) ? "passed" : "failed", errs);
	endtask

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	// The first five forms read Rc and the rest read only Ra or nothing
	function automatic opcode_e pickOpcode(input int n);
		case ($urandom % n)
			0: return OP_R2;
			1: return OP_SHIFT;
			2: return OP_STB;
			3: return OP_STW;
			4: return OP_STO;
			5: return OP_ADDI;
			6: return OP_LDO;
			default: return OP_NOP;
		endcase
	endfunction

	function automatic instrWord_t makeWord(input opcode_e op, input logic immc);
		instrWord_t w;
		w = $urandom;
		w[6:0] = op;
		w[31] = immc;
		return w;
	endfunction

	// A small pool so that fields repeat, including the stack pointer
	function automatic fieldReg_t pickShared();
		case ($urandom % 3)
			0: return 6'd5;
			1: return 6'd6;
			default: return 6'd63;
		endcase
	endfunction

	// ======================================================================
	// Tests
	// ======================================================================

	initial begin
		instrWord_t s0;
		instrWord_t s1;
		opMode_t mode;
		regExt_t ext;
		wbData_t word;
		void'($urandom(32'h2861));
		rstN <= 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		datIn <= '0;
		winSlot0 <= '0;
		winSlot1 <= '0;
		winOm <= '0;
		winRegx <= '0;
		testName <= '0;
		checkResult <= 1'b0;
		checkWord <= 1'b0;
		srcAct <= '0;
		thirdAct <= '0;
		wordExp <= '0;
		wordAct <= '0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		// The model decodes an all zero window as a NOP, so zero is expected
		beginTest("reset_state");
		checkReadback();
		finishTest();

		beginTest("basic_decode");
		for (int i = 0; i < nBasic; i++) begin
			s0 = makeWord(pickOpcode(8), 1'($urandom));
			s1 = $urandom;
			if (s1[6:0] == OP_REGC)
				s1[6:0] = OP_NOP;
			applyWindow(s0, s1, 2'($urandom), 4'($urandom));
			checkReadback();
		end
		finishTest();

		beginTest("regc_override");
		for (int i = 0; i < nRegc; i++) begin
			s0 = makeWord(pickOpcode(8), 1'($urandom));
			s1 = $urandom;
			s1[6:0] = OP_REGC;
			applyWindow(s0, s1, 2'($urandom), 4'($urandom));
			checkReadback();
		end
		finishTest();

		// Field 63 in each position, extension on and off, every mode
		beginTest("stack_pointer");
		for (int m = 0; m < 4; m++) begin
			for (int e = 0; e < 2; e++) begin
				for (int p = 0; p < 4; p++) begin
					s0 = makeWord(OP_R2, 1'b0);
					s0[12:7] = 6'($urandom % 32);
					s0[18:13] = 6'($urandom % 32);
					s0[24:19] = 6'($urandom % 32);
					s0[30:25] = 6'($urandom % 32);
					ext = 4'($urandom);
					case (p)
						0: begin
							s0[18:13] = 6'd63;
							ext[1] = (e != 0);
						end
						1: begin
							s0[24:19] = 6'd63;
							ext[2] = (e != 0);
						end
						2: begin
							s0[30:25] = 6'd63;
							ext[3] = (e != 0);
						end
						default: begin
							s0[6:0] = OP_STO;
							s0[12:7] = 6'd63;
							ext[0] = (e != 0);
						end
					endcase
					applyWindow(s0, 32'd0, 2'(m), ext);
					checkReadback();
				end
			end
		end
		finishTest();

		beginTest("port_count");
		for (int i = 0; i < nPort; i++) begin
			s0 = makeWord(pickOpcode(5), ($urandom % 4) == 0);
			s0[12:7] = pickShared();
			s0[18:13] = pickShared();
			s0[24:19] = pickShared();
			s0[30:25] = pickShared();
			s1 = 32'd0;
			if (($urandom % 4) == 0) begin
				s1 = $urandom;
				s1[6:0] = OP_REGC;
				s1[12:7] = pickShared();
			end
			applyWindow(s0, s1, 2'($urandom), 4'($urandom));
			checkReadback();
		end
		finishTest();

		beginTest("unmapped_write");
		for (int i = 0; i < nUnmapped; i++) begin
			s0 = makeWord(pickOpcode(8), 1'($urandom));
			s1 = $urandom;
			mode = 2'($urandom);
			ext = 4'($urandom);
			applyWindow(s0, s1, mode, ext);
			checkReadback();
			// Result words are read only and addresses 5 to 7 are not mapped at all
			for (int a = 3; a < 8; a++)
				busWrite(wbAddr_t'(a), $urandom);
			checkReadback();
			busRead(REG_SLOT0, word);
			checkWordValue(s0, word);
			busRead(REG_SLOT1, word);
			checkWordValue(s1, word);
			busRead(REG_CTRL, word);
			checkWordValue({26'd0, ext, mode}, word);
			busRead(wbAddr_t'(5 + $urandom % 3), word);
			checkWordValue(32'd0, word);
		end
		repeat (2) @(posedge clk);
		if (ackSeen != transferCount) begin
			tbErrors++;
			$display("Saw %0d acks for %0d transfers", ackSeen, transferCount);
		end
		finishTest();

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, modelErrors + tbErrors);
		if (testsFailed == 0 && modelErrors + tbErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
